// File: design/resp_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "resp_macros.svh"

module resp_apb_regs (
  input  logic                clock,
  input  logic                rstn,
  input  resp_pkg::apb_req_t  apb_req,
  output resp_pkg::apb_rsp_t  apb_rsp,
  output logic                enabled,
  output logic                error_enable,
  output logic                clear_status,
  output logic                clear_counts,
  input  resp_pkg::resp_err_t status,
  input  resp_pkg::resp_cnt_t err_count,
  input  resp_pkg::resp_cnt_t stray_count
);

  logic                access;
  logic                write_access;
  logic                read_access;
  logic                addr_hit;
  logic [1:0]          ctrl_q;  // bit 1 error_enable, bit 0 enabled
  resp_pkg::apb_data_t read_data;

  assign access       = apb_req.psel && apb_req.penable;
  assign write_access = access && apb_req.pwrite;
  assign read_access  = access && !apb_req.pwrite;

  //////////////////////////////
  // address decode and readback
  //////////////////////////////
  always_comb begin
    addr_hit  = 1'b1;
    read_data = '0;
    case (apb_req.paddr)
      `RESP_REG_CTRL:        read_data = resp_pkg::apb_data_t'(ctrl_q);
      `RESP_REG_STATUS:      read_data = resp_pkg::apb_data_t'(status);
      `RESP_REG_ERR_COUNT:   read_data = resp_pkg::apb_data_t'(err_count);
      `RESP_REG_STRAY_COUNT: read_data = resp_pkg::apb_data_t'(stray_count);
      default:               addr_hit  = 1'b0;
    endcase
  end

  //////////////////////////////
  // control register
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ctrl_q <= 2'b00;  // routing off out of reset
    end else if (write_access && apb_req.paddr == `RESP_REG_CTRL) begin
      ctrl_q <= apb_req.pwdata[1:0];
    end
  end

  assign enabled      = ctrl_q[0];
  assign error_enable = ctrl_q[1];

  // write pulses ignore the data value
  assign clear_status = write_access && (apb_req.paddr == `RESP_REG_STATUS);
  assign clear_counts = write_access && (apb_req.paddr == `RESP_REG_ERR_COUNT);

  assign apb_rsp = '{prdata:  read_access ? read_data : '0,
                     pready:  1'b1,                    // no wait states
                     pslverr: access && !addr_hit};

endmodule

`default_nettype wire

// File: design/resp_macros.svh
`ifndef RESP_MACROS_SVH
`define RESP_MACROS_SVH

// tag layout of the host link
`define RESP_TAG_W          8
`define RESP_WED_TAG        8'h00
`define RESP_RESTART_TAG    8'h01
`define RESP_WRITE_TAG_BASE 8'h02  // write tags up to read base - 1
`define RESP_READ_TAG_BASE  8'h80
`define RESP_TAG_UPPER      8'hEF  // above this a tag is stray

`define RESP_CNT_W          16

// register map
`define RESP_APB_AW          4
`define RESP_REG_CTRL        4'h0
`define RESP_REG_STATUS      4'h4
`define RESP_REG_ERR_COUNT   4'h8
`define RESP_REG_STRAY_COUNT 4'hC

`endif

// File: design/resp_pkg.sv
`default_nettype none

`include "resp_macros.svh"

package resp_pkg;

  typedef logic [`RESP_TAG_W-1:0] resp_tag_t;
  typedef logic [`RESP_CNT_W-1:0] resp_cnt_t;
  typedef logic [31:0]            apb_data_t;

  // bit 6 tag parity, then aerror derror flushed fault failed paged
  typedef logic [6:0] resp_err_t;

  typedef enum logic [7:0] {
    code_done    = 8'h00,
    code_aerror  = 8'h01,
    code_derror  = 8'h03,
    code_nlock   = 8'h04,
    code_nres    = 8'h05,
    code_flushed = 8'h06,
    code_fault   = 8'h07,
    code_failed  = 8'h08,
    code_paged   = 8'h0A,
    code_context = 8'h0B
  } resp_code_e;

  typedef struct packed {
    logic       valid;
    resp_tag_t  tag;
    logic       tag_parity;  // odd parity over tag
    resp_code_e code;
  } resp_in_t;

  typedef struct packed {
    logic       wed;
    logic       restart;
    logic       write;
    logic       read;
    logic       valid;
    resp_tag_t  tag;
    resp_code_e code;
    resp_err_t  error;
  } resp_route_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`RESP_APB_AW-1:0] paddr;
    apb_data_t              pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: design/response_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "resp_macros.svh"

module response_control (
  input  logic                  clock,
  input  logic                  rstn,
  input  logic                  enabled,
  input  logic                  error_enable,
  input  resp_pkg::resp_in_t    response,
  output resp_pkg::resp_route_t route,
  output logic                  stray
);

  logic                 s1_valid;
  resp_pkg::resp_tag_t  s1_tag;
  logic                 s1_parity;
  resp_pkg::resp_code_e s1_code;

  logic                 s2_valid;
  logic [3:0]           s2_hit;  // wed, restart, write, read
  resp_pkg::resp_tag_t  s2_tag;
  resp_pkg::resp_code_e s2_code;
  resp_pkg::resp_err_t  s2_error;

  logic [3:0]           out_hit;
  logic                 out_valid;
  logic                 out_stray;
  resp_pkg::resp_tag_t  out_tag;
  resp_pkg::resp_code_e out_code;
  resp_pkg::resp_err_t  out_error;

  logic                 parity_error;
  logic [3:0]           tag_hit;

  // error class bits below the parity bit
  function automatic logic [5:0] code_class(input resp_pkg::resp_code_e code);
    logic [5:0] bits;
    bits = 6'b000000;
    case (code)
      resp_pkg::code_aerror:  bits[5] = 1'b1;
      resp_pkg::code_derror:  bits[4] = 1'b1;
      resp_pkg::code_flushed: bits[3] = 1'b1;
      resp_pkg::code_fault:   bits[2] = 1'b1;
      resp_pkg::code_failed:  bits[1] = 1'b1;
      resp_pkg::code_paged:   bits[0] = 1'b1;
      default:                bits = 6'b000000;  // done, nlock, nres, context
    endcase
    return bits;
  endfunction

  //////////////////////////////
  // stage 1 input latch
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= enabled && response.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && response.valid) begin
      s1_tag    <= response.tag;
      s1_parity <= response.tag_parity;
      s1_code   <= response.code;
    end
  end

  //////////////////////////////
  // stage 2 check and decode
  //////////////////////////////
  assign parity_error = ~(^{s1_tag, s1_parity});  // total ones must be odd

  always_comb begin
    tag_hit = 4'b0000;
    if (s1_tag == `RESP_WED_TAG) begin
      tag_hit[3] = 1'b1;
    end else if (s1_tag == `RESP_RESTART_TAG) begin
      tag_hit[2] = 1'b1;
    end else if (s1_tag >= `RESP_WRITE_TAG_BASE && s1_tag < `RESP_READ_TAG_BASE) begin
      tag_hit[1] = 1'b1;
    end else if (s1_tag >= `RESP_READ_TAG_BASE && s1_tag <= `RESP_TAG_UPPER) begin
      tag_hit[0] = 1'b1;
    end
    // nothing set means stray
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (s1_valid) begin
      s2_hit   <= tag_hit;
      s2_tag   <= s1_tag;
      s2_code  <= s1_code;
      s2_error <= {parity_error, code_class(s1_code)};
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_hit   <= 4'b0000;
      out_valid <= 1'b0;
      out_stray <= 1'b0;
    end else begin
      out_hit   <= s2_valid ? s2_hit : 4'b0000;
      out_valid <= s2_valid && (s2_hit != 4'b0000);
      out_stray <= s2_valid && (s2_hit == 4'b0000);
    end
  end

  always_ff @(posedge clock) begin
    if (s2_valid) begin
      out_tag   <= s2_tag;
      out_code  <= s2_code;
      out_error <= error_enable ? s2_error : '0;  // masked errors read as clean
    end
  end

  assign route = '{wed:     out_hit[3],
                   restart: out_hit[2],
                   write:   out_hit[1],
                   read:    out_hit[0],
                   valid:   out_valid,
                   tag:     out_tag,
                   code:    out_code,
                   error:   out_error};
  assign stray = out_stray;

endmodule

`default_nettype wire

// File: design/response_error_log.sv
`timescale 1ns/1ps
`default_nettype none

module response_error_log (
  input  logic                  clock,
  input  logic                  rstn,
  input  resp_pkg::resp_route_t route,
  input  logic                  stray,
  input  logic                  clear_status,
  input  logic                  clear_counts,
  output resp_pkg::resp_err_t   status,
  output resp_pkg::resp_cnt_t   err_count,
  output resp_pkg::resp_cnt_t   stray_count
);

  resp_pkg::resp_err_t status_q;
  resp_pkg::resp_cnt_t err_count_q;
  resp_pkg::resp_cnt_t stray_count_q;
  logic                err_event;

  // any output, routed or stray, may carry errors
  assign err_event = (route.valid || stray) && (route.error != '0);

  //////////////////////////////
  // sticky status
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      status_q <= '0;
    end else if (clear_status) begin
      status_q <= '0;  // clear beats a new error
    end else if (err_event) begin
      status_q <= status_q | route.error;
    end
  end

  //////////////////////////////
  // saturating counters
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      err_count_q   <= '0;
      stray_count_q <= '0;
    end else if (clear_counts) begin
      err_count_q   <= '0;
      stray_count_q <= '0;
    end else begin
      if (err_event && err_count_q != '1) begin
        err_count_q <= err_count_q + 1'b1;
      end
      if (stray && stray_count_q != '1) begin
        stray_count_q <= stray_count_q + 1'b1;
      end
    end
  end

  assign status      = status_q;
  assign err_count   = err_count_q;
  assign stray_count = stray_count_q;

endmodule

`default_nettype wire

// File: design/response_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module response_unit_top (
  input  logic                  clock,
  input  logic                  rstn,
  input  resp_pkg::resp_in_t    response,
  output resp_pkg::resp_route_t route,
  input  resp_pkg::apb_req_t    apb_req,
  output resp_pkg::apb_rsp_t    apb_rsp
);

  logic                enabled;
  logic                error_enable;
  logic                clear_status;
  logic                clear_counts;
  logic                stray;
  resp_pkg::resp_err_t status;
  resp_pkg::resp_cnt_t err_count;
  resp_pkg::resp_cnt_t stray_count;

  response_control u_control (
    .clock        (clock),
    .rstn         (rstn),
    .enabled      (enabled),
    .error_enable (error_enable),
    .response     (response),
    .route        (route),
    .stray        (stray)
  );

  // log watches the same route the consumers see
  response_error_log u_error_log (
    .clock        (clock),
    .rstn         (rstn),
    .route        (route),
    .stray        (stray),
    .clear_status (clear_status),
    .clear_counts (clear_counts),
    .status       (status),
    .err_count    (err_count),
    .stray_count  (stray_count)
  );

  resp_apb_regs u_apb_regs (
    .clock        (clock),
    .rstn         (rstn),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .enabled      (enabled),
    .error_enable (error_enable),
    .clear_status (clear_status),
    .clear_counts (clear_counts),
    .status       (status),
    .err_count    (err_count),
    .stray_count  (stray_count)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module response_unit_tb -f vlog.f -o response_unit_sim > build.log 2>&1 &&
  ./obj_dir/response_unit_sim > sim.log 2>&1 ||
  echo "build or simulation stopped early, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "^Finished with no errors$" sim.log 2>/dev/null &&
  echo "RESULT: PASS" ||
  { echo "RESULT: FAIL"; exit 1; }

// File: sim/response_unit_properties.sv
`timescale 1ns/1ps
`default_nettype none

module response_unit_properties (
  input logic                  clock,
  input logic                  rstn,
  input resp_pkg::resp_route_t route,
  input logic                  stray
);

  logic [3:0] pulses;

  assign pulses = {route.wed, route.restart, route.write, route.read};

  one_pulse: assert property (@(posedge clock) disable iff (!rstn) $onehot0(pulses))
    else $error("more than one route pulse high");

  valid_matches_pulses: assert property (@(posedge clock) disable iff (!rstn)
    route.valid == (pulses != 4'b0000))
    else $error("route valid does not match the route pulses");

  stray_not_routed: assert property (@(posedge clock) disable iff (!rstn)
    !(stray && route.valid))
    else $error("stray and route valid high together");

  // outputs idle while reset is held
  quiet_in_reset: assert property (@(posedge clock)
    !rstn |-> (pulses == 4'b0000 && !route.valid && !stray))
    else $error("route outputs active during reset");

endmodule

bind response_control response_unit_properties u_properties (
  .clock (clock),
  .rstn  (rstn),
  .route (route),
  .stray (stray)
);

`default_nettype wire

// File: sim/response_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "resp_macros.svh"

module response_unit_tb;

  logic                  clock;
  logic                  rstn;
  resp_pkg::resp_in_t    response;
  resp_pkg::resp_route_t route;
  resp_pkg::apb_req_t    apb_req;
  resp_pkg::apb_rsp_t    apb_rsp;
  int                    error_count;
  int                    check_count;
  integer                seed;

  localparam logic [7:0] code_list [10] = '{8'h00, 8'h01, 8'h03, 8'h04, 8'h05,
                                            8'h06, 8'h07, 8'h08, 8'h0A, 8'h0B};

  tb_clock_gen u_clock_gen (.clock(clock), .rstn(rstn));

  response_unit_top dut (
    .clock    (clock),
    .rstn     (rstn),
    .response (response),
    .route    (route),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp)
  );

  //////////////////////////////
  // expected values
  //////////////////////////////
  function automatic logic odd_parity(input logic [7:0] tag);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += tag[i];
    end
    return (ones % 2) == 0;  // parity bit makes the total odd
  endfunction

  // wed, restart, write, read
  function automatic logic [3:0] expect_route(input logic [7:0] tag);
    if (tag == `RESP_WED_TAG) return 4'b1000;
    if (tag == `RESP_RESTART_TAG) return 4'b0100;
    if (tag < `RESP_READ_TAG_BASE) return 4'b0010;
    if (tag <= `RESP_TAG_UPPER) return 4'b0001;
    return 4'b0000;
  endfunction

  function automatic logic [6:0] expect_error(input logic [7:0] code, input logic corrupt,
                                              input logic err_en);
    logic [6:0] e;
    e = 7'b0000000;
    case (code)
      8'h01: e[5] = 1'b1;  // aerror
      8'h03: e[4] = 1'b1;
      8'h06: e[3] = 1'b1;
      8'h07: e[2] = 1'b1;
      8'h08: e[1] = 1'b1;
      8'h0A: e[0] = 1'b1;  // paged
      default: e = 7'b0000000;
    endcase
    e[6] = corrupt;
    return err_en ? e : 7'b0000000;
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
    end
  endtask

  //////////////////////////////
  // drivers
  //////////////////////////////
  task automatic apb_access(input logic write, input logic [`RESP_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    int waited;
    @(negedge clock);
    apb_req.psel    = 1'b1;  // setup cycle
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clock);
    apb_req.penable = 1'b1;
    #2;
    waited = 0;
    while (!apb_rsp.pready && waited < 10) begin
      @(negedge clock);
      #2;
      waited++;
    end
    if (!apb_rsp.pready) begin
      error_count++;
      $display("APB access to offset %0h never saw pready", addr);
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clock);
    apb_req = '0;
  endtask

  task automatic reg_write(input logic [`RESP_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, data, rdata, slverr);
    check_value("pslverr on write", slverr, 0);
  endtask

  task automatic reg_expect(input logic [`RESP_APB_AW-1:0] addr, input logic [31:0] expected,
                            input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, 0, rdata, slverr);
    check_value(what, rdata, expected);
    check_value("pslverr on read", slverr, 0);
  endtask

  task automatic send_response(input logic [7:0] tag, input logic [7:0] code,
                               input logic corrupt);
    @(negedge clock);
    response.valid      = 1'b1;
    response.tag        = tag;
    response.tag_parity = odd_parity(tag) ^ corrupt;
    response.code       = resp_pkg::resp_code_e'(code);
    @(negedge clock);
    response.valid = 1'b0;
  endtask

  // first route or stray output within 10 cycles
  task automatic wait_output(output int cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 10) begin
      @(negedge clock);
      cycles++;
      seen = route.valid || dut.stray;
    end
    if (!seen) begin
      error_count++;
      $display("no route or stray output within 10 cycles at %0t ns", $time);
    end
  endtask

  task automatic check_output(input logic [7:0] tag, input logic [7:0] code,
                              input logic corrupt, input logic err_en);
    logic [3:0] hit;
    hit = expect_route(tag);
    check_value("route pulses", {route.wed, route.restart, route.write, route.read}, hit);
    check_value("route valid", route.valid, hit != 4'b0000);
    check_value("stray pulse", dut.stray, hit == 4'b0000);
    check_value("route tag", route.tag, tag);
    check_value("route code", route.code, code);
    check_value("error vector", route.error, expect_error(code, corrupt, err_en));
  endtask

  task automatic send_and_check(input logic [7:0] tag, input logic [7:0] code,
                                input logic corrupt, input logic err_en);
    int cycles;
    send_response(tag, code, corrupt);
    wait_output(cycles);
    check_value("response latency", cycles, 2);
    check_output(tag, code, corrupt, err_en);
    @(negedge clock);
    check_value("single cycle output", {route.valid, dut.stray}, 2'b00);
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic test_registers();
    logic [31:0] rdata;
    logic        slverr;
    reg_expect(`RESP_REG_CTRL, 0, "control after reset");
    reg_expect(`RESP_REG_STATUS, 0, "status after reset");
    reg_expect(`RESP_REG_ERR_COUNT, 0, "err_count after reset");
    reg_expect(`RESP_REG_STRAY_COUNT, 0, "stray_count after reset");
    reg_write(`RESP_REG_CTRL, 32'h3);
    reg_expect(`RESP_REG_CTRL, 32'h3, "control readback");
    reg_write(`RESP_REG_CTRL, 32'h2);
    reg_expect(`RESP_REG_CTRL, 32'h2, "control readback");
    apb_access(1'b0, 4'h2, 0, rdata, slverr);  // unmapped
    check_value("pslverr on unmapped offset", slverr, 1);
  endtask

  task automatic test_routing();
    int   waited;
    logic seen;
    reg_write(`RESP_REG_CTRL, 32'h3);
    send_and_check(8'h00, 8'h00, 1'b0, 1'b1);
    send_and_check(8'h01, 8'h00, 1'b0, 1'b1);
    send_and_check(8'h40, 8'h04, 1'b0, 1'b1);
    send_and_check(8'hA0, 8'h0B, 1'b0, 1'b1);
    reg_write(`RESP_REG_CTRL, 32'h2);  // routing off
    send_response(8'h40, 8'h00, 1'b0);
    seen   = 1'b0;
    waited = 0;
    while (waited < 6) begin
      @(negedge clock);
      seen = seen || route.valid || dut.stray;
      waited++;
    end
    check_value("output while disabled", seen, 0);
  endtask

  task automatic test_error_classes();
    reg_write(`RESP_REG_CTRL, 32'h3);
    for (int i = 0; i < 10; i++) begin
      send_and_check(8'h10, code_list[i], 1'b0, 1'b1);
    end
    reg_write(`RESP_REG_CTRL, 32'h1);  // errors masked with routing on
    send_and_check(8'h40, 8'h01, 1'b0, 1'b0);
    send_and_check(8'h90, 8'h07, 1'b1, 1'b0);
  endtask

  task automatic test_parity();
    reg_write(`RESP_REG_CTRL, 32'h3);
    reg_write(`RESP_REG_STATUS, 0);
    reg_expect(`RESP_REG_STATUS, 0, "status after clear");
    send_and_check(8'h22, 8'h00, 1'b1, 1'b1);
    reg_expect(`RESP_REG_STATUS, 32'h40, "status after parity error");
    send_and_check(8'h22, 8'h00, 1'b0, 1'b1);
    reg_expect(`RESP_REG_STATUS, 32'h40, "sticky parity status");
    reg_write(`RESP_REG_STATUS, 0);
    reg_expect(`RESP_REG_STATUS, 0, "status after clear");
  endtask

  task automatic test_stray_counts();
    reg_write(`RESP_REG_CTRL, 32'h3);
    reg_write(`RESP_REG_ERR_COUNT, 0);
    send_and_check(8'hF5, 8'h00, 1'b0, 1'b1);
    reg_expect(`RESP_REG_STRAY_COUNT, 1, "stray_count after stray tag");
    send_and_check(8'h30, 8'h01, 1'b0, 1'b1);
    send_and_check(8'h90, 8'h07, 1'b0, 1'b1);
    send_and_check(8'h01, 8'h0A, 1'b0, 1'b1);
    send_and_check(8'h05, 8'h00, 1'b0, 1'b1);
    reg_expect(`RESP_REG_ERR_COUNT, 3, "err_count");
    reg_expect(`RESP_REG_STRAY_COUNT, 1, "stray_count");
    reg_write(`RESP_REG_ERR_COUNT, 0);
    reg_expect(`RESP_REG_ERR_COUNT, 0, "err_count after clear");
    reg_expect(`RESP_REG_STRAY_COUNT, 0, "stray_count after clear");
  endtask

  task automatic test_pipeline();
    logic [7:0]  tags [20];
    logic [7:0]  codes [20];
    logic [31:0] r;
    int          n;
    int          got;
    for (int i = 0; i < 20; i++) begin
      r        = $random(seed);
      tags[i]  = r[7:0];
      r        = $random(seed);
      codes[i] = code_list[r[15:0] % 10];
    end
    reg_write(`RESP_REG_CTRL, 32'h3);
    n   = 0;
    got = 0;
    while (got < 20 && n < 40) begin
      @(negedge clock);
      if (route.valid || dut.stray) begin
        check_output(tags[got], codes[got], 1'b0, 1'b1);
        got++;
      end else if (got > 0) begin
        error_count++;
        $display("gap in back-to-back output after %0d responses at %0t ns", got, $time);
      end
      if (n < 20) begin
        response.valid      = 1'b1;
        response.tag        = tags[n];
        response.tag_parity = odd_parity(tags[n]);
        response.code       = resp_pkg::resp_code_e'(codes[n]);
      end else begin
        response.valid = 1'b0;
      end
      n++;
    end
    response.valid = 1'b0;
    if (got < 20) begin
      error_count++;
      $display("only %0d of 20 pipelined responses came out", got);
    end
  endtask

  initial begin
    int waited;
    response    = '0;
    apb_req     = '0;
    error_count = 0;
    check_count = 0;
    seed        = 32'h531;
    waited      = 0;
    while (rstn !== 1'b1 && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (rstn !== 1'b1) begin
      error_count++;
      $display("reset was never released");
    end
    check_value("route valid after reset", route.valid, 0);
    test_registers();
    test_routing();
    test_error_classes();
    test_parity();
    test_stray_counts();
    test_pipeline();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic rstn
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;  // 10 ns period
  end

  // reset held for 4 cycles and released on a falling edge
  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/resp_pkg.sv
design/response_control.sv
design/response_error_log.sv
design/resp_apb_regs.sv
design/response_unit_top.sv
sim/tb_clock_gen.sv
sim/response_unit_properties.sv
sim/response_unit_tb.sv
